//--- common/ctl_if.sv
// Control bundle between the controller and the datapath.
// All fields are combinational and valid within the current cycle.
interface ctl_if;
  logic       regfile_write_enable;
  logic       alu_operand_a_select;
  logic       alu_operand_b_select;
  logic [1:0] alu_op_type;
  logic       data_mem_read_enable;
  logic       data_mem_write_enable;
  logic [2:0] reg_writeback_select;
  logic [1:0] next_pc_select;
  // branch outcome back from the alu
  logic       take_branch;

  modport control (
    output regfile_write_enable, alu_operand_a_select, alu_operand_b_select, alu_op_type,
    output data_mem_read_enable, data_mem_write_enable, reg_writeback_select, next_pc_select,
    input  take_branch
  );

  modport datapath (
    input  regfile_write_enable, alu_operand_a_select, alu_operand_b_select, alu_op_type,
    input  data_mem_read_enable, data_mem_write_enable, reg_writeback_select, next_pc_select,
    output take_branch
  );
endinterface

//--- common/rv_ctl_pkg.sv
// Control field encodings driven by the controller and decoded in the datapath and ALU.
package rv_ctl_pkg;

  // next pc source
  localparam logic [1:0] CTL_PC_PC4     = 2'b00;
  localparam logic [1:0] CTL_PC_PC_IMM  = 2'b01;
  localparam logic [1:0] CTL_PC_RS1_IMM = 2'b10;

  // alu operand sources
  localparam logic CTL_ALU_A_RS1 = 1'b0;
  localparam logic CTL_ALU_A_PC  = 1'b1;
  localparam logic CTL_ALU_B_RS2 = 1'b0;
  localparam logic CTL_ALU_B_IMM = 1'b1;

  // alu operation class, refined by funct3/funct7 inside the alu
  localparam logic [1:0] CTL_ALU_ADD    = 2'b00;
  localparam logic [1:0] CTL_ALU_OP     = 2'b01;
  localparam logic [1:0] CTL_ALU_OP_IMM = 2'b10;
  localparam logic [1:0] CTL_ALU_BRANCH = 2'b11;

  // register writeback source
  localparam logic [2:0] CTL_WRITEBACK_ALU  = 3'b000;
  localparam logic [2:0] CTL_WRITEBACK_DATA = 3'b001;
  localparam logic [2:0] CTL_WRITEBACK_PC4  = 3'b010;
  localparam logic [2:0] CTL_WRITEBACK_IMM  = 3'b011;

endpackage

//--- common/rv_isa_pkg.sv
// RV32I instruction set definitions shared by the core and the testbench.
// Holds the opcodes, the funct3 codes, the instruction formats and the reset vector.
package rv_isa_pkg;

  typedef enum logic [6:0] {
    OPCODE_LOAD     = 7'b0000011,
    OPCODE_MISC_MEM = 7'b0001111,
    OPCODE_OP_IMM   = 7'b0010011,
    OPCODE_AUIPC    = 7'b0010111,
    OPCODE_STORE    = 7'b0100011,
    OPCODE_OP       = 7'b0110011,
    OPCODE_LUI      = 7'b0110111,
    OPCODE_BRANCH   = 7'b1100011,
    OPCODE_JALR     = 7'b1100111,
    OPCODE_JAL      = 7'b1101111
  } opcode_t;

  // alu funct3
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [31:0] RESET_VECTOR = 32'h0000_0000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_type_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_type_t;

  // one instruction word, seen through each encoding format
  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } instr_t;

endpackage

//--- datapath/alu.sv
// Integer ALU of the core, also used for the branch comparison.
// The operation class comes from the controller, the detail from funct3/funct7.
module alu (
  input  logic [1:0]  op_type,
  input  logic [2:0]  funct3,
  input  logic        funct7_5,
  input  logic [31:0] operand_a,
  input  logic [31:0] operand_b,
  output logic [31:0] result
);

  logic [4:0]  shamt;
  logic [31:0] sra_result;
  logic        branch_cond;

  assign shamt      = operand_b[4:0];
  assign sra_result = $signed(operand_a) >>> shamt;

  always_comb begin
    case (funct3)
      rv_isa_pkg::F3_BEQ:  branch_cond = operand_a == operand_b;
      rv_isa_pkg::F3_BNE:  branch_cond = operand_a != operand_b;
      rv_isa_pkg::F3_BLT:  branch_cond = $signed(operand_a) < $signed(operand_b);
      rv_isa_pkg::F3_BGE:  branch_cond = $signed(operand_a) >= $signed(operand_b);
      rv_isa_pkg::F3_BLTU: branch_cond = operand_a < operand_b;
      rv_isa_pkg::F3_BGEU: branch_cond = operand_a >= operand_b;
      default:             branch_cond = 1'b0;
    endcase
  end

  always_comb begin
    case (op_type)
      rv_ctl_pkg::CTL_ALU_OP, rv_ctl_pkg::CTL_ALU_OP_IMM: begin
        case (funct3)
          rv_isa_pkg::F3_ADD_SUB: begin
            // sub only exists in the register form, addi reuses the bit as immediate
            if (op_type == rv_ctl_pkg::CTL_ALU_OP && funct7_5) begin
              result = operand_a - operand_b;
            end else begin
              result = operand_a + operand_b;
            end
          end
          rv_isa_pkg::F3_SLL:  result = operand_a << shamt;
          rv_isa_pkg::F3_SLT:  result = {31'd0, $signed(operand_a) < $signed(operand_b)};
          rv_isa_pkg::F3_SLTU: result = {31'd0, operand_a < operand_b};
          rv_isa_pkg::F3_XOR:  result = operand_a ^ operand_b;
          rv_isa_pkg::F3_SR:   result = funct7_5 ? sra_result : (operand_a >> shamt);
          rv_isa_pkg::F3_OR:   result = operand_a | operand_b;
          default:             result = operand_a & operand_b;
        endcase
      end
      rv_ctl_pkg::CTL_ALU_BRANCH: result = {31'd0, branch_cond};
      // address and pc arithmetic
      default: result = operand_a + operand_b;
    endcase
  end

endmodule

//--- datapath/regfile.sv
// Integer register file, two combinational read ports and one write port.
// x0 reads as zero and ignores writes.
module regfile (
  input  logic        clock,
  input  logic        write_enable,
  input  logic [4:0]  rd_addr,
  input  logic [4:0]  rs1_addr,
  input  logic [4:0]  rs2_addr,
  input  logic [31:0] rd_data,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data
);

  logic [31:0] regs [32];

  always_ff @(posedge clock) begin
    if (write_enable && rd_addr != 5'd0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? 32'd0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? 32'd0 : regs[rs2_addr];

endmodule

//--- datapath/singlecycle_datapath.sv
// Datapath of the single-cycle core: pc, immediates, register file, alu and muxes.
// Retires one instruction per clock under control of singlecycle_control.
module singlecycle_datapath (
  input  logic               clock,
  input  logic               reset,
  input  rv_isa_pkg::instr_t inst_data,
  output logic [31:0]        inst_addr,
  output logic [31:0]        data_addr,
  output logic [31:0]        data_wdata,
  input  logic [31:0]        data_rdata,
  output logic               data_read_enable,
  output logic               data_write_enable,
  ctl_if.datapath            ctl
);

  logic [31:0] pc;
  logic [31:0] pc_plus_4;
  logic [31:0] next_pc;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;
  logic [31:0] imm;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] rd_data;
  logic [31:0] alu_operand_a;
  logic [31:0] alu_operand_b;
  logic [31:0] alu_result;
  logic        regfile_write_enable;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= rv_isa_pkg::RESET_VECTOR;
    end else begin
      pc <= next_pc;
    end
  end

  assign inst_addr = pc;
  assign pc_plus_4 = pc + 32'd4;

  // immediates, sign extended from the top instruction bit
  assign imm_i = {{20{inst_data.i.imm_11_0[11]}}, inst_data.i.imm_11_0};
  assign imm_s = {{20{inst_data.s.imm_11_5[6]}}, inst_data.s.imm_11_5, inst_data.s.imm_4_0};
  assign imm_b = {{19{inst_data.b.imm_12}}, inst_data.b.imm_12, inst_data.b.imm_11,
                  inst_data.b.imm_10_5, inst_data.b.imm_4_1, 1'b0};
  assign imm_u = {inst_data.u.imm_31_12, 12'b0};
  assign imm_j = {{11{inst_data.j.imm_20}}, inst_data.j.imm_20, inst_data.j.imm_19_12,
                  inst_data.j.imm_11, inst_data.j.imm_10_1, 1'b0};

  always_comb begin
    case (rv_isa_pkg::opcode_t'(inst_data.r.opcode))
      rv_isa_pkg::OPCODE_STORE:  imm = imm_s;
      rv_isa_pkg::OPCODE_BRANCH: imm = imm_b;
      rv_isa_pkg::OPCODE_LUI:    imm = imm_u;
      rv_isa_pkg::OPCODE_AUIPC:  imm = imm_u;
      rv_isa_pkg::OPCODE_JAL:    imm = imm_j;
      default:                   imm = imm_i;
    endcase
  end

  // nothing is committed while reset is held
  assign regfile_write_enable = ctl.regfile_write_enable & ~reset;
  assign data_read_enable     = ctl.data_mem_read_enable & ~reset;
  assign data_write_enable    = ctl.data_mem_write_enable & ~reset;

  regfile regs (
    .clock        (clock),
    .write_enable (regfile_write_enable),
    .rd_addr      (inst_data.r.rd),
    .rs1_addr     (inst_data.r.rs1),
    .rs2_addr     (inst_data.r.rs2),
    .rd_data      (rd_data),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data)
  );

  assign alu_operand_a = (ctl.alu_operand_a_select == rv_ctl_pkg::CTL_ALU_A_PC) ? pc : rs1_data;
  assign alu_operand_b = (ctl.alu_operand_b_select == rv_ctl_pkg::CTL_ALU_B_IMM) ? imm : rs2_data;

  alu alu (
    .op_type   (ctl.alu_op_type),
    .funct3    (inst_data.r.funct3),
    .funct7_5  (inst_data.r.funct7[5]),
    .operand_a (alu_operand_a),
    .operand_b (alu_operand_b),
    .result    (alu_result)
  );

  assign ctl.take_branch = (ctl.alu_op_type == rv_ctl_pkg::CTL_ALU_BRANCH) & alu_result[0];

  // loads and stores always address rs1+imm
  assign data_addr  = alu_result;
  assign data_wdata = rs2_data;

  always_comb begin
    case (ctl.reg_writeback_select)
      rv_ctl_pkg::CTL_WRITEBACK_DATA: rd_data = data_rdata;
      rv_ctl_pkg::CTL_WRITEBACK_PC4:  rd_data = pc_plus_4;
      rv_ctl_pkg::CTL_WRITEBACK_IMM:  rd_data = imm;
      default:                        rd_data = alu_result;
    endcase
  end

  always_comb begin
    case (ctl.next_pc_select)
      rv_ctl_pkg::CTL_PC_PC_IMM:  next_pc = pc + imm;
      // jalr target, lowest bit dropped
      rv_ctl_pkg::CTL_PC_RS1_IMM: next_pc = {alu_result[31:1], 1'b0};
      default:                    next_pc = pc_plus_4;
    endcase
  end

endmodule

//--- src/simple_core.sv
// Top level of the single-cycle RV32I core.
// Memories sit outside and answer combinationally on the plain ports.
module simple_core (
  input  logic        clock,
  input  logic        reset,
  output logic [31:0] inst_addr,
  input  logic [31:0] inst_data,
  output logic [31:0] data_addr,
  output logic [31:0] data_wdata,
  input  logic [31:0] data_rdata,
  output logic        data_read_enable,
  output logic        data_write_enable
);

  ctl_if ctl ();

  singlecycle_control control (
    .inst_opcode (rv_isa_pkg::opcode_t'(inst_data[6:0])),
    .ctl         (ctl.control)
  );

  singlecycle_datapath datapath (
    .clock             (clock),
    .reset             (reset),
    .inst_data         (inst_data),
    .inst_addr         (inst_addr),
    .data_addr         (data_addr),
    .data_wdata        (data_wdata),
    .data_rdata        (data_rdata),
    .data_read_enable  (data_read_enable),
    .data_write_enable (data_write_enable),
    .ctl               (ctl.datapath)
  );

endmodule

//--- src/singlecycle_control.sv
// Main decoder of the single-cycle core.
// Turns the opcode into the full set of datapath controls in zero cycles.
module singlecycle_control (
  input rv_isa_pkg::opcode_t inst_opcode,
  ctl_if.control             ctl
);

  always_comb begin
    // unknown opcodes and fence fall through as a nop
    ctl.regfile_write_enable  = 1'b0;
    ctl.alu_operand_a_select  = rv_ctl_pkg::CTL_ALU_A_RS1;
    ctl.alu_operand_b_select  = rv_ctl_pkg::CTL_ALU_B_RS2;
    ctl.alu_op_type           = rv_ctl_pkg::CTL_ALU_ADD;
    ctl.data_mem_read_enable  = 1'b0;
    ctl.data_mem_write_enable = 1'b0;
    ctl.reg_writeback_select  = rv_ctl_pkg::CTL_WRITEBACK_ALU;
    case (inst_opcode)
      rv_isa_pkg::OPCODE_LOAD: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_b_select = rv_ctl_pkg::CTL_ALU_B_IMM;
        ctl.data_mem_read_enable = 1'b1;
        ctl.reg_writeback_select = rv_ctl_pkg::CTL_WRITEBACK_DATA;
      end
      rv_isa_pkg::OPCODE_STORE: begin
        ctl.alu_operand_b_select  = rv_ctl_pkg::CTL_ALU_B_IMM;
        ctl.data_mem_write_enable = 1'b1;
      end
      rv_isa_pkg::OPCODE_OP_IMM: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_b_select = rv_ctl_pkg::CTL_ALU_B_IMM;
        ctl.alu_op_type          = rv_ctl_pkg::CTL_ALU_OP_IMM;
      end
      rv_isa_pkg::OPCODE_OP: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_op_type          = rv_ctl_pkg::CTL_ALU_OP;
      end
      rv_isa_pkg::OPCODE_AUIPC: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_a_select = rv_ctl_pkg::CTL_ALU_A_PC;
        ctl.alu_operand_b_select = rv_ctl_pkg::CTL_ALU_B_IMM;
      end
      rv_isa_pkg::OPCODE_LUI: begin
        // immediate goes straight to rd, alu result unused
        ctl.regfile_write_enable = 1'b1;
        ctl.reg_writeback_select = rv_ctl_pkg::CTL_WRITEBACK_IMM;
      end
      rv_isa_pkg::OPCODE_BRANCH: begin
        ctl.alu_op_type = rv_ctl_pkg::CTL_ALU_BRANCH;
      end
      rv_isa_pkg::OPCODE_JALR: begin
        // alu forms rs1+imm as the jump target
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_b_select = rv_ctl_pkg::CTL_ALU_B_IMM;
        ctl.reg_writeback_select = rv_ctl_pkg::CTL_WRITEBACK_PC4;
      end
      rv_isa_pkg::OPCODE_JAL: begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_a_select = rv_ctl_pkg::CTL_ALU_A_PC;
        ctl.alu_operand_b_select = rv_ctl_pkg::CTL_ALU_B_IMM;
        ctl.reg_writeback_select = rv_ctl_pkg::CTL_WRITEBACK_PC4;
      end
      default: begin
      end
    endcase
  end

  // kept apart from the main decode since it depends on the branch outcome
  always_comb begin
    case (inst_opcode)
      rv_isa_pkg::OPCODE_BRANCH:
        ctl.next_pc_select = ctl.take_branch ? rv_ctl_pkg::CTL_PC_PC_IMM
                                             : rv_ctl_pkg::CTL_PC_PC4;
      rv_isa_pkg::OPCODE_JALR: ctl.next_pc_select = rv_ctl_pkg::CTL_PC_RS1_IMM;
      rv_isa_pkg::OPCODE_JAL:  ctl.next_pc_select = rv_ctl_pkg::CTL_PC_PC_IMM;
      default:                 ctl.next_pc_select = rv_ctl_pkg::CTL_PC_PC4;
    endcase
  end

endmodule

//--- testbench/clock_gen.sv
// Testbench clock with a 10 ns period and a synchronous reset held for 4 cycles.
// hold_reset raises reset after an edge, release_reset drops it 4 edges later.
module clock_gen (
  output logic clock,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    forever #5 clock = ~clock;
  end

  task automatic hold_reset();
    @(posedge clock);
    #1 reset = 1'b1;
  endtask

  // 4 rising edges pass with reset high
  task automatic release_reset();
    repeat (4) @(posedge clock);
    #1 reset = 1'b0;
  endtask

endmodule

//--- testbench/core_asserts.sv
// Concurrent checks on the datapath memory strobes and fetch address.
// Attached to every singlecycle_datapath instance through bind.
module core_asserts (
  input logic        clock,
  input logic        reset,
  input logic [31:0] inst_addr,
  input logic        data_read_enable,
  input logic        data_write_enable
);
  timeunit 1ns;
  timeprecision 100ps;

  // fetch stays on word boundaries
  pc_aligned: assert property (@(posedge clock) disable iff (reset) inst_addr[1:0] == 2'b00)
    else $error("inst_addr %h is not word aligned", inst_addr);

  strobes_exclusive: assert property (@(posedge clock) !(data_read_enable && data_write_enable))
    else $error("data read and write strobes are high together");

  quiet_in_reset: assert property (@(posedge clock)
    reset |-> !data_read_enable && !data_write_enable)
    else $error("data strobe high while reset is held");

endmodule

bind singlecycle_datapath core_asserts checks (
  .clock             (clock),
  .reset             (reset),
  .inst_addr         (inst_addr),
  .data_read_enable  (data_read_enable),
  .data_write_enable (data_write_enable)
);

//--- testbench/core_tb.sv
// Directed testbench for simple_core with word memories on the plain ports.
// Each test assembles a small program, runs it until a store to the halt
// address and compares data memory with values worked out from RV32I rules.
module core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] HALT_ADDR = 32'h100;
  // funct3 per test slot, slot 0 in the low bits
  localparam logic [29:0] RR_FUNCT3 = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
  localparam logic [9:0]  RR_ALT    = 10'b0010000010;
  localparam logic [26:0] RI_FUNCT3 = {3'd5, 3'd5, 3'd1, 3'd7, 3'd6, 3'd4, 3'd3, 3'd2, 3'd0};

  logic        clock;
  logic        reset;
  logic [31:0] inst_addr;
  logic [31:0] inst_data;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic [31:0] data_rdata;
  logic        data_read_enable;
  logic        data_write_enable;

  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  logic [31:0] reg_value [32];
  logic [31:0] seed;
  int          prog_len;
  int          error_count;
  int          check_count;
  int          test_count;
  int          errors_at_start;
  string       exp_name [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_value [$];

  clock_gen clocks (
    .clock (clock),
    .reset (reset)
  );

  simple_core UUT (
    .clock             (clock),
    .reset             (reset),
    .inst_addr         (inst_addr),
    .inst_data         (inst_data),
    .data_addr         (data_addr),
    .data_wdata        (data_wdata),
    .data_rdata        (data_rdata),
    .data_read_enable  (data_read_enable),
    .data_write_enable (data_write_enable)
  );

  // both memories answer combinationally, data writes land on the edge
  assign inst_data  = imem[inst_addr[9:2]];
  // data reads return zero unless the read strobe is high
  assign data_rdata = data_read_enable ? dmem[data_addr[9:2]] : 32'h0;

  always @(posedge clock) begin
    if (data_write_enable) begin
      dmem[data_addr[9:2]] <= data_wdata;
    end
  end

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [31:0] fill_value(int index);
    return 32'hd5a0_0000 | index;
  endfunction

  function automatic logic [31:0] op_word(logic [2:0] funct3, logic alt, logic [4:0] rd,
                                          logic [4:0] rs1, logic [4:0] rs2);
    rv_isa_pkg::instr_t w;
    w.r.funct7 = {1'b0, alt, 5'b0};
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = funct3;
    w.r.rd     = rd;
    w.r.opcode = rv_isa_pkg::OPCODE_OP;
    return w;
  endfunction

  function automatic logic [31:0] imm_word(logic [6:0] opcode, logic [2:0] funct3,
                                           logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    rv_isa_pkg::instr_t w;
    w.i.imm_11_0 = imm;
    w.i.rs1      = rs1;
    w.i.funct3   = funct3;
    w.i.rd       = rd;
    w.i.opcode   = opcode;
    return w;
  endfunction

  // always a word store
  function automatic logic [31:0] store_word(logic [4:0] rs1, logic [4:0] rs2,
                                             logic [11:0] offset);
    rv_isa_pkg::instr_t w;
    w.s.imm_11_5 = offset[11:5];
    w.s.rs2      = rs2;
    w.s.rs1      = rs1;
    w.s.funct3   = 3'b010;
    w.s.imm_4_0  = offset[4:0];
    w.s.opcode   = rv_isa_pkg::OPCODE_STORE;
    return w;
  endfunction

  function automatic logic [31:0] branch_word(logic [2:0] funct3, logic [4:0] rs1,
                                              logic [4:0] rs2, logic [12:0] offset);
    rv_isa_pkg::instr_t w;
    w.b.imm_12   = offset[12];
    w.b.imm_10_5 = offset[10:5];
    w.b.rs2      = rs2;
    w.b.rs1      = rs1;
    w.b.funct3   = funct3;
    w.b.imm_4_1  = offset[4:1];
    w.b.imm_11   = offset[11];
    w.b.opcode   = rv_isa_pkg::OPCODE_BRANCH;
    return w;
  endfunction

  function automatic logic [31:0] upper_word(logic [6:0] opcode, logic [4:0] rd,
                                             logic [19:0] imm);
    rv_isa_pkg::instr_t w;
    w.u.imm_31_12 = imm;
    w.u.rd        = rd;
    w.u.opcode    = opcode;
    return w;
  endfunction

  function automatic logic [31:0] jal_word(logic [4:0] rd, logic [20:0] offset);
    rv_isa_pkg::instr_t w;
    w.j.imm_20    = offset[20];
    w.j.imm_10_1  = offset[10:1];
    w.j.imm_11    = offset[11];
    w.j.imm_19_12 = offset[19:12];
    w.j.rd        = rd;
    w.j.opcode    = rv_isa_pkg::OPCODE_JAL;
    return w;
  endfunction

  // RV32I integer arithmetic, alt is instruction bit 30
  function automatic logic [31:0] expected_alu(logic [2:0] funct3, logic alt,
                                               logic [31:0] a, logic [31:0] b);
    case (funct3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return {31'd0, $signed(a) < $signed(b)};
      3'd3: return {31'd0, a < b};
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[prog_len] = w;
    prog_len++;
  endtask

  // lui + addi, upper part rounded for the sign of the low twelve bits
  task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    emit(upper_word(rv_isa_pkg::OPCODE_LUI, rd, upper[31:12]));
    emit(imm_word(rv_isa_pkg::OPCODE_OP_IMM, rv_isa_pkg::F3_ADD_SUB, rd, rd, value[11:0]));
    reg_value[rd] = value;
  endtask

  task automatic halt_here();
    emit(store_word(5'd0, 5'd0, HALT_ADDR[11:0]));
  endtask

  task automatic expect_word(input string name, input logic [31:0] addr,
                             input logic [31:0] value);
    exp_name.push_back(name);
    exp_addr.push_back(addr);
    exp_value.push_back(value);
  endtask

  // unused words jump to themselves so a finished program parks
  task automatic start_program();
    for (int i = 0; i < 256; i++) begin
      imem[i] = jal_word(5'd0, 21'd0);
      dmem[i] = fill_value(i);
    end
    prog_len = 0;
    errors_at_start = error_count;
    exp_name.delete();
    exp_addr.delete();
    exp_value.delete();
  endtask

  task automatic run_program(input string test_name);
    int          cycles;
    bit          halted;
    string       name;
    logic [31:0] addr;
    logic [31:0] expected;
    cycles = 0;
    halted = 1'b0;
    while (!halted && cycles < 200) begin
      @(negedge clock);
      halted = data_write_enable && data_addr == HALT_ADDR;
      cycles++;
    end
    if (!halted) begin
      $display("%s: program did not reach halt", test_name);
      error_count++;
    end else begin
      @(posedge clock);
      #1;
      while (exp_addr.size() > 0) begin
        name     = exp_name.pop_front();
        addr     = exp_addr.pop_front();
        expected = exp_value.pop_front();
        check_count++;
        if (dmem[addr[9:2]] !== expected) begin
          $display("Fail at %0d ns: %s expected %h got %h", $time, name, expected,
                   dmem[addr[9:2]]);
          error_count++;
        end
      end
    end
    test_count++;
    $display("%-16s done, %0d errors", test_name, error_count - errors_at_start);
  endtask

  task automatic reset_test();
    clocks.hold_reset();
    start_program();
    // a store at the reset vector must stay quiet until reset drops
    emit(store_word(5'd0, 5'd0, 12'h040));
    halt_here();
    expect_word("store after reset", 32'h40, 32'h0);
    fork
      clocks.release_reset();
      begin
        @(posedge clock);
        repeat (3) begin
          @(negedge clock);
          check_count++;
          if (inst_addr !== rv_isa_pkg::RESET_VECTOR) begin
            $display("Fail at %0d ns: inst_addr expected %h got %h", $time,
                     rv_isa_pkg::RESET_VECTOR, inst_addr);
            error_count++;
          end
          if (data_read_enable !== 1'b0 || data_write_enable !== 1'b0) begin
            $display("Fail at %0d ns: data strobes expected 00 got %b%b", $time,
                     data_read_enable, data_write_enable);
            error_count++;
          end
        end
      end
    join
    @(negedge clock);
    check_count++;
    if (inst_addr !== rv_isa_pkg::RESET_VECTOR) begin
      $display("Fail at %0d ns: inst_addr expected %h got %h", $time,
               rv_isa_pkg::RESET_VECTOR, inst_addr);
      error_count++;
    end
    run_program("reset");
  endtask

  task automatic alu_test();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_value;
    logic [31:0] operand;
    logic [11:0] imm_field;
    logic [2:0]  funct3;
    logic        alt;
    clocks.hold_reset();
    start_program();
    a = next_random();
    b = next_random();
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int k = 0; k < 10; k++) begin
      funct3 = RR_FUNCT3[k*3 +: 3];
      alt    = RR_ALT[k];
      emit(op_word(funct3, alt, 5'd3, 5'd1, 5'd2));
      emit(store_word(5'd0, 5'd3, 12'h180 + 4 * k));
      expect_word($sformatf("reg-reg op %0d", k), 32'h180 + 4 * k,
                  expected_alu(funct3, alt, a, b));
    end
    for (int k = 0; k < 9; k++) begin
      funct3    = RI_FUNCT3[k*3 +: 3];
      alt       = (k == 8);
      imm_value = next_random();
      // shifts carry shamt and the sra bit in the immediate
      if (funct3 == rv_isa_pkg::F3_SLL || funct3 == rv_isa_pkg::F3_SR) begin
        imm_field = {1'b0, alt, 5'b0, imm_value[4:0]};
      end else begin
        imm_field = imm_value[11:0];
      end
      operand = {{20{imm_field[11]}}, imm_field};
      emit(imm_word(rv_isa_pkg::OPCODE_OP_IMM, funct3, 5'd4, 5'd1, imm_field));
      emit(store_word(5'd0, 5'd4, 12'h1c0 + 4 * k));
      expect_word($sformatf("reg-imm op %0d", k), 32'h1c0 + 4 * k,
                  expected_alu(funct3, alt, a, operand));
    end
    halt_here();
    clocks.release_reset();
    run_program("alu");
  endtask

  task automatic load_store_test();
    logic [31:0] value;
    clocks.hold_reset();
    start_program();
    value = next_random();
    load_const(5'd5, value);
    emit(store_word(5'd0, 5'd5, 12'h200));
    emit(imm_word(rv_isa_pkg::OPCODE_LOAD, 3'b010, 5'd6, 5'd0, 12'h200));
    emit(imm_word(rv_isa_pkg::OPCODE_OP_IMM, rv_isa_pkg::F3_ADD_SUB, 5'd6, 5'd6, 12'd1));
    emit(store_word(5'd0, 5'd6, 12'h204));
    emit(imm_word(rv_isa_pkg::OPCODE_OP_IMM, rv_isa_pkg::F3_ADD_SUB, 5'd0, 5'd0, 12'h055));
    emit(store_word(5'd0, 5'd0, 12'h208));
    halt_here();
    expect_word("stored word", 32'h200, value);
    expect_word("loaded word plus 1", 32'h204, value + 32'd1);
    expect_word("x0 after write", 32'h208, 32'h0);
    clocks.release_reset();
    run_program("load/store");
  endtask

  // marker 2 on the taken path, 1 on the fall-through path
  task automatic branch_case(input logic [2:0] funct3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input int slot);
    logic [31:0] a;
    logic [31:0] b;
    bit          taken;
    a = reg_value[rs1];
    b = reg_value[rs2];
    case (funct3)
      rv_isa_pkg::F3_BEQ:  taken = a == b;
      rv_isa_pkg::F3_BNE:  taken = a != b;
      rv_isa_pkg::F3_BLT:  taken = $signed(a) < $signed(b);
      rv_isa_pkg::F3_BGE:  taken = $signed(a) >= $signed(b);
      rv_isa_pkg::F3_BLTU: taken = a < b;
      default:             taken = a >= b;
    endcase
    emit(branch_word(funct3, rs1, rs2, 13'd12));
    emit(imm_word(rv_isa_pkg::OPCODE_OP_IMM, rv_isa_pkg::F3_ADD_SUB, 5'd7, 5'd0, 12'd1));
    emit(jal_word(5'd0, 21'd8));
    emit(imm_word(rv_isa_pkg::OPCODE_OP_IMM, rv_isa_pkg::F3_ADD_SUB, 5'd7, 5'd0, 12'd2));
    emit(store_word(5'd0, 5'd7, 12'h220 + 4 * slot));
    expect_word($sformatf("branch marker %0d", slot), 32'h220 + 4 * slot, taken ? 32'd2 : 32'd1);
  endtask

  task automatic branch_test();
    clocks.hold_reset();
    start_program();
    load_const(5'd1, 32'd5);
    load_const(5'd2, 32'hffff_fffd);
    load_const(5'd3, 32'd5);
    branch_case(rv_isa_pkg::F3_BEQ, 5'd1, 5'd3, 0);
    branch_case(rv_isa_pkg::F3_BEQ, 5'd1, 5'd2, 1);
    branch_case(rv_isa_pkg::F3_BNE, 5'd1, 5'd2, 2);
    branch_case(rv_isa_pkg::F3_BNE, 5'd1, 5'd3, 3);
    branch_case(rv_isa_pkg::F3_BLT, 5'd2, 5'd1, 4);
    branch_case(rv_isa_pkg::F3_BLT, 5'd1, 5'd2, 5);
    branch_case(rv_isa_pkg::F3_BGE, 5'd1, 5'd2, 6);
    branch_case(rv_isa_pkg::F3_BGE, 5'd2, 5'd1, 7);
    branch_case(rv_isa_pkg::F3_BLTU, 5'd1, 5'd2, 8);
    branch_case(rv_isa_pkg::F3_BLTU, 5'd2, 5'd1, 9);
    branch_case(rv_isa_pkg::F3_BGEU, 5'd2, 5'd1, 10);
    branch_case(rv_isa_pkg::F3_BGEU, 5'd1, 5'd2, 11);
    halt_here();
    clocks.release_reset();
    run_program("branches");
  endtask

  task automatic jump_test();
    logic [31:0] auipc_addr;
    logic [31:0] jal_addr;
    logic [31:0] jalr_addr;
    clocks.hold_reset();
    start_program();
    emit(imm_word(rv_isa_pkg::OPCODE_OP_IMM, rv_isa_pkg::F3_ADD_SUB, 5'd11, 5'd0, 12'd0));
    auipc_addr = prog_len * 4;
    emit(upper_word(rv_isa_pkg::OPCODE_AUIPC, 5'd8, 20'h12345));
    jal_addr = prog_len * 4;
    emit(jal_word(5'd9, 21'd8));
    // skipped by the jal
    emit(imm_word(rv_isa_pkg::OPCODE_OP_IMM, rv_isa_pkg::F3_ADD_SUB, 5'd11, 5'd0, 12'h066));
    jalr_addr = (prog_len + 2) * 4;
    load_const(5'd12, jalr_addr + 32'd8);
    // offset 1 makes the raw target odd
    emit(imm_word(rv_isa_pkg::OPCODE_JALR, 3'b000, 5'd13, 5'd12, 12'd1));
    emit(imm_word(rv_isa_pkg::OPCODE_OP_IMM, rv_isa_pkg::F3_ADD_SUB, 5'd11, 5'd0, 12'h077));
    emit(upper_word(rv_isa_pkg::OPCODE_AUIPC, 5'd15, 20'h0));
    emit(store_word(5'd0, 5'd8, 12'h240));
    emit(store_word(5'd0, 5'd9, 12'h244));
    emit(store_word(5'd0, 5'd13, 12'h248));
    emit(store_word(5'd0, 5'd15, 12'h24c));
    emit(store_word(5'd0, 5'd11, 12'h250));
    halt_here();
    expect_word("auipc result", 32'h240, auipc_addr + 32'h1234_5000);
    expect_word("jal link", 32'h244, jal_addr + 32'd4);
    expect_word("jalr link", 32'h248, jalr_addr + 32'd4);
    expect_word("jalr target", 32'h24c, jalr_addr + 32'd8);
    expect_word("skipped words", 32'h250, 32'h0);
    clocks.release_reset();
    run_program("jumps");
  endtask

  task automatic unknown_opcode_test();
    logic [31:0] value;
    clocks.hold_reset();
    start_program();
    value = next_random();
    load_const(5'd14, value);
    emit(store_word(5'd0, 5'd14, 12'h280));
    // custom-0 opcode, rd = x14 and an i-type address field of 0x288
    emit(upper_word(7'b0001011, 5'd14, 20'h28802));
    emit(store_word(5'd0, 5'd14, 12'h284));
    halt_here();
    expect_word("word before", 32'h280, value);
    expect_word("x14 after", 32'h284, value);
    // every other word keeps its fill pattern
    for (int i = 0; i < 256; i++) begin
      if (i != (32'h280 >> 2) && i != (32'h284 >> 2) && i != (HALT_ADDR >> 2)) begin
        expect_word($sformatf("untouched word %0d", i), i * 4, fill_value(i));
      end
    end
    clocks.release_reset();
    run_program("unknown opcode");
  endtask

  initial begin
    seed        = 32'd9;
    error_count = 0;
    check_count = 0;
    test_count  = 0;
    start_program();
    reset_test();
    alu_test();
    load_store_test();
    branch_test();
    jump_test();
    unknown_opcode_test();
    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
common/rv_isa_pkg.sv
common/rv_ctl_pkg.sv
common/ctl_if.sv
datapath/regfile.sv
datapath/alu.sv
datapath/singlecycle_datapath.sv
src/singlecycle_control.sv
src/simple_core.sv
testbench/clock_gen.sv
testbench/core_asserts.sv
testbench/core_tb.sv
